// ==== common/snoop_pkg.sv ====
// Shared definitions for the control-flow snooper:
// trace field types, stored entry type, register indices and CTRL bit layout,
// and the recording engine state encoding

package snoop_pkg;

   // Trace record fields
   typedef logic [31:0] pc_t;
   // Privilege level: user 0, supervisor 1, machine 3
   typedef logic [1:0]  priv_t;
   typedef logic [6:0]  opcode_t;

   // Stored record, from the top down: priv, opcode, source pc, destination pc
   typedef logic [72:0] trace_entry_t;

   // Register port
   typedef logic [2:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   localparam reg_addr_t REG_CTRL     = 3'd0;
   localparam reg_addr_t REG_RANGE_LO = 3'd1;
   localparam reg_addr_t REG_RANGE_HI = 3'd2;
   localparam reg_addr_t REG_TRIG_PC  = 3'd3;
   // Read-only status
   localparam reg_addr_t REG_FIRST    = 3'd4;
   localparam reg_addr_t REG_LAST     = 3'd5;
   localparam reg_addr_t REG_COUNT    = 3'd6;

   // CTRL bit positions
   localparam int unsigned CTRL_EN_BIT   = 0;
   localparam int unsigned CTRL_CLR_BIT  = 1;
   localparam int unsigned CTRL_MASK_LSB = 2;
   localparam int unsigned CTRL_NUM_LSB  = 8;

   // Frozen flag inside REG_COUNT
   localparam int unsigned COUNT_FROZEN_BIT = 31;

   // Recording engine states
   typedef enum logic [1:0] {
      IDLE,
      ARMED,
      FROZEN
   } snoop_state_e;

endpackage

// ==== design/wrap_counter.sv ====
// Write pointer of the circular buffer
// Fill count saturating at DEPTH, wrap flag, oldest and newest index

`timescale 1ns/1ps

module wrap_counter #(
   parameter int unsigned DEPTH = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     clr_i,
   input  logic                     adv_i,
   output logic [$clog2(DEPTH)-1:0] wr_ptr_o,
   output logic [$clog2(DEPTH)-1:0] first_o,
   output logic [$clog2(DEPTH)-1:0] last_o,
   output logic [$clog2(DEPTH):0]   count_o,
   output logic                     wrapped_o
);

   localparam int unsigned PTR_W = $clog2(DEPTH);
   localparam int unsigned CNT_W = PTR_W + 1;

   logic full;

   assign full = (count_o == CNT_W'(DEPTH));

   always_ff @(posedge clk_i) begin
      if (rst_i || clr_i) begin
         wr_ptr_o  <= '0;
         count_o   <= '0;
         wrapped_o <= 1'b0;
      end else if (adv_i) begin
         // Power of two depth, so the pointer wraps by itself
         wr_ptr_o <= wr_ptr_o + 1'b1;
         if (!full) begin
            count_o <= count_o + 1'b1;
         end
         if (wr_ptr_o == PTR_W'(DEPTH - 1)) begin
            wrapped_o <= 1'b1;
         end
      end
   end

   // Oldest entry sits at the write pointer once overwritten
   assign first_o = wrapped_o ? wr_ptr_o : '0;

   // Newest entry, zero while empty
   assign last_o = (count_o == '0) ? '0 : wr_ptr_o - 1'b1;

   a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      count_o <= CNT_W'(DEPTH));

endmodule

// ==== design/trigger_unit.sv ====
// Trigger on the Nth accepted record whose destination matches trig_pc_i
// A match number of zero behaves as one

`timescale 1ns/1ps

module trigger_unit (
   input  logic           clk_i,
   input  logic           rst_i,
   input  logic           clr_i,
   input  logic           accept_i,
   input  snoop_pkg::pc_t rec_pc_dst_i,
   input  snoop_pkg::pc_t trig_pc_i,
   input  logic [7:0]     trig_num_i,
   output logic           fire_o
);

   logic [7:0] match_cnt_q;
   logic [7:0] target;
   logic       match;

   assign match  = accept_i && (rec_pc_dst_i == trig_pc_i);
   assign target = (trig_num_i == '0) ? 8'd1 : trig_num_i;

   // Fires together with the write of the matching record
   assign fire_o = match && ({1'b0, match_cnt_q} + 9'd1 == {1'b0, target});

   always_ff @(posedge clk_i) begin
      if (rst_i || clr_i) begin
         match_cnt_q <= '0;
      end else if (match && match_cnt_q != 8'hff) begin
         match_cnt_q <= match_cnt_q + 1'b1;
      end
   end

endmodule

// ==== snooper/snoop_cfg_regs.sv ====
// Configuration and status register bank
// Strobe-based write and read port, registered read data

`timescale 1ns/1ps

module snoop_cfg_regs #(
   parameter int unsigned DEPTH = 16
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  cfg_we_i,
   input  logic                  cfg_re_i,
   input  snoop_pkg::reg_addr_t  cfg_addr_i,
   input  snoop_pkg::reg_data_t  cfg_wdata_i,
   input  logic [$clog2(DEPTH)-1:0] first_i,
   input  logic [$clog2(DEPTH)-1:0] last_i,
   input  logic [$clog2(DEPTH):0]   count_i,
   input  logic                  frozen_i,
   output snoop_pkg::reg_data_t  cfg_rdata_o,
   output logic                  cfg_rvalid_o,
   output logic                  enable_o,
   output logic                  clear_o,
   output logic [3:0]            priv_mask_o,
   output snoop_pkg::pc_t        range_lo_o,
   output snoop_pkg::pc_t        range_hi_o,
   output snoop_pkg::pc_t        trig_pc_o,
   output logic [7:0]            trig_num_o
);

   logic                 ctrl_wr;
   snoop_pkg::reg_data_t rdata_d;

   assign ctrl_wr = cfg_we_i && (cfg_addr_i == snoop_pkg::REG_CTRL);

   //////////////////////////////////////////////////
   // Writable registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_o    <= 1'b0;
         clear_o     <= 1'b0;
         priv_mask_o <= '0;
         trig_num_o  <= '0;
         range_lo_o  <= '0;
         range_hi_o  <= '0;
         trig_pc_o   <= '0;
      end else begin
         // Clear is a one-cycle pulse
         clear_o <= ctrl_wr && cfg_wdata_i[snoop_pkg::CTRL_CLR_BIT];
         if (ctrl_wr) begin
            enable_o    <= cfg_wdata_i[snoop_pkg::CTRL_EN_BIT];
            priv_mask_o <= cfg_wdata_i[snoop_pkg::CTRL_MASK_LSB +: 4];
            trig_num_o  <= cfg_wdata_i[snoop_pkg::CTRL_NUM_LSB +: 8];
         end
         if (cfg_we_i && cfg_addr_i == snoop_pkg::REG_RANGE_LO) begin
            range_lo_o <= cfg_wdata_i;
         end
         if (cfg_we_i && cfg_addr_i == snoop_pkg::REG_RANGE_HI) begin
            range_hi_o <= cfg_wdata_i;
         end
         if (cfg_we_i && cfg_addr_i == snoop_pkg::REG_TRIG_PC) begin
            trig_pc_o <= cfg_wdata_i;
         end
      end
   end

   //////////////////////////////////////////////////
   // Read decode
   //////////////////////////////////////////////////

   always_comb begin
      rdata_d = '0;
      case (cfg_addr_i)
         snoop_pkg::REG_CTRL: begin
            rdata_d[snoop_pkg::CTRL_EN_BIT]         = enable_o;
            rdata_d[snoop_pkg::CTRL_MASK_LSB +: 4]  = priv_mask_o;
            rdata_d[snoop_pkg::CTRL_NUM_LSB +: 8]   = trig_num_o;
         end
         snoop_pkg::REG_RANGE_LO: rdata_d = range_lo_o;
         snoop_pkg::REG_RANGE_HI: rdata_d = range_hi_o;
         snoop_pkg::REG_TRIG_PC:  rdata_d = trig_pc_o;
         snoop_pkg::REG_FIRST:    rdata_d = snoop_pkg::reg_data_t'(first_i);
         snoop_pkg::REG_LAST:     rdata_d = snoop_pkg::reg_data_t'(last_i);
         snoop_pkg::REG_COUNT: begin
            rdata_d = snoop_pkg::reg_data_t'(count_i);
            rdata_d[snoop_pkg::COUNT_FROZEN_BIT] = frozen_i;
         end
         default: rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cfg_rvalid_o <= 1'b0;
         cfg_rdata_o  <= '0;
      end else begin
         cfg_rvalid_o <= cfg_re_i;
         if (cfg_re_i) begin
            cfg_rdata_o <= rdata_d;
         end
      end
   end

endmodule

// ==== snooper/trace_filter.sv ====
// Acceptance filter for the captured trace record
// Privilege mask and inclusive destination window

`timescale 1ns/1ps

module trace_filter (
   input  logic             rec_valid_i,
   input  snoop_pkg::priv_t rec_priv_i,
   input  snoop_pkg::pc_t   rec_pc_dst_i,
   input  logic [3:0]       priv_mask_i,
   input  snoop_pkg::pc_t   range_lo_i,
   input  snoop_pkg::pc_t   range_hi_i,
   output logic             pass_o
);

   logic priv_ok;
   logic in_window;

   // Mask bit indexed by privilege level
   assign priv_ok = priv_mask_i[rec_priv_i];

   // Both bounds are inclusive
   assign in_window = (rec_pc_dst_i >= range_lo_i) && (rec_pc_dst_i <= range_hi_i);

   assign pass_o = rec_valid_i && priv_ok && in_window;

endmodule

// ==== snooper/snoop_engine.sv ====
// Recording engine of the snooper
// Input capture register for the core trace record and the
// IDLE / ARMED / FROZEN state machine that steers buffer, counter and trigger

`timescale 1ns/1ps

module snoop_engine (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     trace_valid_i,
   input  snoop_pkg::pc_t           pc_src_i,
   input  snoop_pkg::pc_t           pc_dst_i,
   input  snoop_pkg::priv_t         priv_i,
   input  snoop_pkg::opcode_t       opcode_i,
   input  logic                     enable_i,
   input  logic                     clear_i,
   input  logic                     pass_i,
   input  logic                     fire_i,
   output logic                     rec_valid_o,
   output snoop_pkg::priv_t         rec_priv_o,
   output snoop_pkg::pc_t           rec_pc_dst_o,
   output logic                     wr_en_o,
   output snoop_pkg::trace_entry_t  wr_entry_o,
   output logic                     accept_o,
   output logic                     clr_o,
   output logic                     frozen_o
);

   snoop_pkg::snoop_state_e state_q;
   snoop_pkg::snoop_state_e state_d;
   snoop_pkg::pc_t          rec_pc_src;
   snoop_pkg::opcode_t      rec_opcode;

   //////////////////////////////////////////////////
   // Capture register
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rec_valid_o <= 1'b0;
      end else begin
         rec_valid_o <= trace_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      rec_priv_o   <= priv_i;
      rec_pc_src   <= pc_src_i;
      rec_pc_dst_o <= pc_dst_i;
      rec_opcode   <= opcode_i;
   end

   assign wr_entry_o = {rec_priv_o, rec_opcode, rec_pc_src, rec_pc_dst_o};

   //////////////////////////////////////////////////
   // Recording state machine
   //////////////////////////////////////////////////

   // A clear cycle stores nothing
   assign accept_o = (state_q == snoop_pkg::ARMED) && enable_i && !clear_i && pass_i;
   assign wr_en_o  = accept_o;
   assign frozen_o = (state_q == snoop_pkg::FROZEN);

   // Restart pointer and match count on arming or on a host clear
   assign clr_o = clear_i || ((state_q == snoop_pkg::IDLE) && enable_i);

   always_comb begin
      state_d = state_q;
      if (!enable_i) begin
         state_d = snoop_pkg::IDLE;
      end else if (clear_i) begin
         state_d = snoop_pkg::ARMED;
      end else begin
         case (state_q)
            snoop_pkg::IDLE:  state_d = snoop_pkg::ARMED;
            snoop_pkg::ARMED: begin
               if (accept_o && fire_i) begin
                  state_d = snoop_pkg::FROZEN;
               end
            end
            default: state_d = state_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= snoop_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   //////////////////////////////////////////////////
   // Assertions
   //////////////////////////////////////////////////

   a_wr_only_armed: assert property (@(posedge clk_i) disable iff (rst_i)
      wr_en_o |-> state_q == snoop_pkg::ARMED);

endmodule

// ==== snooper/trace_buffer.sv ====
// Circular trace entry memory
// One write port from the engine, one registered read port for the host

`timescale 1ns/1ps

module trace_buffer #(
   parameter int unsigned DEPTH = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     wr_en_i,
   input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
   input  snoop_pkg::trace_entry_t  wr_entry_i,
   input  logic                     rd_en_i,
   input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
   output snoop_pkg::trace_entry_t  rd_entry_o,
   output logic                     rd_valid_o
);

   snoop_pkg::trace_entry_t mem_q [DEPTH];

   // Entry array
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem_q[wr_addr_i] <= wr_entry_i;
      end
   end

   // Registered read data
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_entry_o <= mem_q[rd_addr_i];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

endmodule

// ==== snooper/snooper_top.sv ====
// Control-flow trace snooper top level
// Register bank, capture and state machine, filter, circular buffer,
// write pointer and trigger

`timescale 1ns/1ps

module snooper_top #(
   parameter int unsigned DEPTH = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // Core trace port
   input  logic                     trace_valid_i,
   input  snoop_pkg::pc_t           pc_src_i,
   input  snoop_pkg::pc_t           pc_dst_i,
   input  snoop_pkg::priv_t         priv_i,
   input  snoop_pkg::opcode_t       opcode_i,
   // Host register port
   input  logic                     cfg_we_i,
   input  logic                     cfg_re_i,
   input  snoop_pkg::reg_addr_t     cfg_addr_i,
   input  snoop_pkg::reg_data_t     cfg_wdata_i,
   output snoop_pkg::reg_data_t     cfg_rdata_o,
   output logic                     cfg_rvalid_o,
   // Host buffer read port
   input  logic                     buf_re_i,
   input  logic [$clog2(DEPTH)-1:0] buf_addr_i,
   output snoop_pkg::trace_entry_t  buf_rdata_o,
   output logic                     buf_rvalid_o,
   output logic                     trigger_o
);

   localparam int unsigned PTR_W = $clog2(DEPTH);

   logic                    enable;
   logic                    clear;
   logic [3:0]              priv_mask;
   snoop_pkg::pc_t          range_lo;
   snoop_pkg::pc_t          range_hi;
   snoop_pkg::pc_t          trig_pc;
   logic [7:0]              trig_num;

   logic                    rec_valid;
   snoop_pkg::priv_t        rec_priv;
   snoop_pkg::pc_t          rec_pc_dst;
   logic                    pass;
   logic                    accept;
   logic                    fire;
   logic                    clr;
   logic                    wr_en;
   snoop_pkg::trace_entry_t wr_entry;

   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        first;
   logic [PTR_W-1:0]        last;
   logic [PTR_W:0]          count;

   //////////////////////////////////////////////////
   // Configuration
   //////////////////////////////////////////////////

   snoop_cfg_regs #(
      .DEPTH        ( DEPTH        )
   ) i_cfg_regs (
      .clk_i        ( clk_i        ),
      .rst_i        ( rst_i        ),
      .cfg_we_i     ( cfg_we_i     ),
      .cfg_re_i     ( cfg_re_i     ),
      .cfg_addr_i   ( cfg_addr_i   ),
      .cfg_wdata_i  ( cfg_wdata_i  ),
      .first_i      ( first        ),
      .last_i       ( last         ),
      .count_i      ( count        ),
      .frozen_i     ( trigger_o    ),
      .cfg_rdata_o  ( cfg_rdata_o  ),
      .cfg_rvalid_o ( cfg_rvalid_o ),
      .enable_o     ( enable       ),
      .clear_o      ( clear        ),
      .priv_mask_o  ( priv_mask    ),
      .range_lo_o   ( range_lo     ),
      .range_hi_o   ( range_hi     ),
      .trig_pc_o    ( trig_pc      ),
      .trig_num_o   ( trig_num     )
   );

   //////////////////////////////////////////////////
   // Capture, filter and trigger
   //////////////////////////////////////////////////

   snoop_engine i_engine (
      .clk_i         ( clk_i         ),
      .rst_i         ( rst_i         ),
      .trace_valid_i ( trace_valid_i ),
      .pc_src_i      ( pc_src_i      ),
      .pc_dst_i      ( pc_dst_i      ),
      .priv_i        ( priv_i        ),
      .opcode_i      ( opcode_i      ),
      .enable_i      ( enable        ),
      .clear_i       ( clear         ),
      .pass_i        ( pass          ),
      .fire_i        ( fire          ),
      .rec_valid_o   ( rec_valid     ),
      .rec_priv_o    ( rec_priv      ),
      .rec_pc_dst_o  ( rec_pc_dst    ),
      .wr_en_o       ( wr_en         ),
      .wr_entry_o    ( wr_entry      ),
      .accept_o      ( accept        ),
      .clr_o         ( clr           ),
      .frozen_o      ( trigger_o     )
   );

   trace_filter i_filter (
      .rec_valid_i  ( rec_valid  ),
      .rec_priv_i   ( rec_priv   ),
      .rec_pc_dst_i ( rec_pc_dst ),
      .priv_mask_i  ( priv_mask  ),
      .range_lo_i   ( range_lo   ),
      .range_hi_i   ( range_hi   ),
      .pass_o       ( pass       )
   );

   trigger_unit i_trigger (
      .clk_i        ( clk_i      ),
      .rst_i        ( rst_i      ),
      .clr_i        ( clr        ),
      .accept_i     ( accept     ),
      .rec_pc_dst_i ( rec_pc_dst ),
      .trig_pc_i    ( trig_pc    ),
      .trig_num_i   ( trig_num   ),
      .fire_o       ( fire       )
   );

   //////////////////////////////////////////////////
   // Circular buffer
   //////////////////////////////////////////////////

   wrap_counter #(
      .DEPTH     ( DEPTH  )
   ) i_wrap_counter (
      .clk_i     ( clk_i  ),
      .rst_i     ( rst_i  ),
      .clr_i     ( clr    ),
      .adv_i     ( wr_en  ),
      .wr_ptr_o  ( wr_ptr ),
      .first_o   ( first  ),
      .last_o    ( last   ),
      .count_o   ( count  ),
      .wrapped_o (        )
   );

   trace_buffer #(
      .DEPTH      ( DEPTH        )
   ) i_trace_buffer (
      .clk_i      ( clk_i        ),
      .rst_i      ( rst_i        ),
      .wr_en_i    ( wr_en        ),
      .wr_addr_i  ( wr_ptr       ),
      .wr_entry_i ( wr_entry     ),
      .rd_en_i    ( buf_re_i     ),
      .rd_addr_i  ( buf_addr_i   ),
      .rd_entry_o ( buf_rdata_o  ),
      .rd_valid_o ( buf_rvalid_o )
   );

endmodule

// ==== tests/tb_snooper_tasks.svh ====
// Host port tasks of the snooper testbench
// Register write, register read and trace buffer read
// Each read waits for its valid strobe with a timeout

task automatic write_reg(input snoop_pkg::reg_addr_t addr, input snoop_pkg::reg_data_t data);
   @(posedge clk_i);
   cfg_we_i    <= 1'b1;
   cfg_addr_i  <= addr;
   cfg_wdata_i <= data;
   @(posedge clk_i);
   cfg_we_i <= 1'b0;
endtask

task automatic read_reg(input snoop_pkg::reg_addr_t addr, output snoop_pkg::reg_data_t data);
   int wait_cnt;
   wait_cnt = 0;
   @(posedge clk_i);
   cfg_re_i   <= 1'b1;
   cfg_addr_i <= addr;
   @(posedge clk_i);
   cfg_re_i <= 1'b0;
   @(negedge clk_i);
   while (!cfg_rvalid_o && wait_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      wait_cnt++;
   end
   if (cfg_rvalid_o) begin
      data = cfg_rdata_o;
   end else begin
      data = '0;
      report_error($sformatf("no response to the read of register %0d", addr));
   end
endtask

task automatic read_entry(input int idx, output snoop_pkg::trace_entry_t entry);
   int wait_cnt;
   wait_cnt = 0;
   @(posedge clk_i);
   buf_re_i   <= 1'b1;
   buf_addr_i <= 4'(idx);
   @(posedge clk_i);
   buf_re_i <= 1'b0;
   @(negedge clk_i);
   while (!buf_rvalid_o && wait_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      wait_cnt++;
   end
   if (buf_rvalid_o) begin
      entry = buf_rdata_o;
   end else begin
      entry = '0;
      report_error($sformatf("no response to the read of buffer entry %0d", idx));
   end
endtask

// ==== tests/tb_snooper.sv ====
// Testbench of the control-flow trace snooper
// Clock and reset, stimulus table, queue reference model,
// register and buffer checks, closing summary

`timescale 1ns/1ps

module tb_snooper;

   localparam int DEPTH          = 16;
   localparam int TIMEOUT_CYCLES = 20;

   // One table row, keep is the expected filter result
   typedef struct packed {
      logic               valid;
      snoop_pkg::priv_t   priv;
      snoop_pkg::pc_t     src;
      snoop_pkg::pc_t     dst;
      snoop_pkg::opcode_t op;
      logic               keep;
   } row_t;

   logic                    clk_i;
   logic                    rst_i;
   logic                    trace_valid_i;
   snoop_pkg::pc_t          pc_src_i;
   snoop_pkg::pc_t          pc_dst_i;
   snoop_pkg::priv_t        priv_i;
   snoop_pkg::opcode_t      opcode_i;
   logic                    cfg_we_i;
   logic                    cfg_re_i;
   snoop_pkg::reg_addr_t    cfg_addr_i;
   snoop_pkg::reg_data_t    cfg_wdata_i;
   snoop_pkg::reg_data_t    cfg_rdata_o;
   logic                    cfg_rvalid_o;
   logic                    buf_re_i;
   logic [3:0]              buf_addr_i;
   snoop_pkg::trace_entry_t buf_rdata_o;
   logic                    buf_rvalid_o;
   logic                    trigger_o;

   integer                  seed;
   row_t                    rows [$];
   snoop_pkg::reg_data_t    rd_word;
   int                      n_err;
   int                      n_tests;
   int                      n_failed;
   int                      err_base;

   // Reference model state
   snoop_pkg::trace_entry_t model_q [$];
   logic                    m_en;
   logic [3:0]              m_mask;
   logic [7:0]              m_tnum;
   snoop_pkg::pc_t          m_lo;
   snoop_pkg::pc_t          m_hi;
   snoop_pkg::pc_t          m_tpc;
   int                      m_n;
   int                      m_match;
   logic                    m_frozen;

   snooper_top #(
      .DEPTH         ( DEPTH         )
   ) i_dut (
      .clk_i         ( clk_i         ),
      .rst_i         ( rst_i         ),
      .trace_valid_i ( trace_valid_i ),
      .pc_src_i      ( pc_src_i      ),
      .pc_dst_i      ( pc_dst_i      ),
      .priv_i        ( priv_i        ),
      .opcode_i      ( opcode_i      ),
      .cfg_we_i      ( cfg_we_i      ),
      .cfg_re_i      ( cfg_re_i      ),
      .cfg_addr_i    ( cfg_addr_i    ),
      .cfg_wdata_i   ( cfg_wdata_i   ),
      .cfg_rdata_o   ( cfg_rdata_o   ),
      .cfg_rvalid_o  ( cfg_rvalid_o  ),
      .buf_re_i      ( buf_re_i      ),
      .buf_addr_i    ( buf_addr_i    ),
      .buf_rdata_o   ( buf_rdata_o   ),
      .buf_rvalid_o  ( buf_rvalid_o  ),
      .trigger_o     ( trigger_o     )
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic report_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      n_err++;
   endtask

   task automatic report_mismatch(input string name, input logic [72:0] got,
                                  input logic [72:0] exp);
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      n_err++;
   endtask

   `include "tb_snooper_tasks.svh"

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic snoop_pkg::reg_data_t ctrl_word(input logic en, input logic clr,
                                                      input logic [3:0] mask,
                                                      input logic [7:0] num);
      return {16'h0000, num, 2'b00, mask, clr, en};
   endfunction

   function automatic bit filter_rule(input row_t r);
      return r.valid && m_mask[r.priv] && (r.dst >= m_lo) && (r.dst <= m_hi);
   endfunction

   function automatic void model_step(input row_t r);
      int target;
      target = (m_tnum == 8'd0) ? 1 : int'(m_tnum);
      if (m_en && !m_frozen && filter_rule(r)) begin
         model_q.push_back({r.priv, r.op, r.src, r.dst});
         // Oldest record is overwritten once the buffer is full
         if (model_q.size() > DEPTH) begin
            void'(model_q.pop_front());
         end
         m_n++;
         if (r.dst == m_tpc) begin
            m_match++;
            if (m_match == target) begin
               m_frozen = 1'b1;
            end
         end
      end
   endfunction

   task automatic set_ctrl(input logic en, input logic clr, input logic [3:0] mask,
                           input logic [7:0] num);
      write_reg(snoop_pkg::REG_CTRL, ctrl_word(en, clr, mask, num));
      // Arming or a clear restarts pointer and match count
      if (clr || (en && !m_en)) begin
         model_q.delete();
         m_n      = 0;
         m_match  = 0;
         m_frozen = 1'b0;
      end
      if (!en) begin
         m_frozen = 1'b0;
      end
      m_en   = en;
      m_mask = mask;
      m_tnum = num;
   endtask

   task automatic set_window(input snoop_pkg::pc_t lo, input snoop_pkg::pc_t hi,
                             input snoop_pkg::pc_t tpc);
      write_reg(snoop_pkg::REG_RANGE_LO, lo);
      write_reg(snoop_pkg::REG_RANGE_HI, hi);
      write_reg(snoop_pkg::REG_TRIG_PC, tpc);
      m_lo  = lo;
      m_hi  = hi;
      m_tpc = tpc;
   endtask

   task automatic add_row(input logic valid, input snoop_pkg::priv_t priv,
                          input snoop_pkg::pc_t dst, input logic keep);
      row_t r;
      r.valid = valid;
      r.priv  = priv;
      r.src   = $random(seed);
      r.dst   = dst;
      r.op    = 7'($random(seed));
      r.keep  = keep;
      rows.push_back(r);
   endtask

   //////////////////////////////////////////////////
   // Stimulus and checks
   //////////////////////////////////////////////////

   // One row per cycle; trigger_o follows the model two edges later
   task automatic apply_table();
      logic frz_hist [$];
      int   i;
      frz_hist.push_back(m_frozen);
      frz_hist.push_back(m_frozen);
      for (i = 0; i < rows.size(); i++) begin
         @(posedge clk_i);
         trace_valid_i <= rows[i].valid;
         priv_i        <= rows[i].priv;
         pc_src_i      <= rows[i].src;
         pc_dst_i      <= rows[i].dst;
         opcode_i      <= rows[i].op;
         if (filter_rule(rows[i]) !== rows[i].keep) begin
            report_error($sformatf("table row %0d disagrees with the filter rule", i));
         end
         model_step(rows[i]);
         frz_hist.push_back(m_frozen);
         @(negedge clk_i);
         if (trigger_o !== frz_hist[i]) begin
            report_mismatch("trigger_o", 73'(trigger_o), 73'(frz_hist[i]));
         end
      end
      @(posedge clk_i);
      trace_valid_i <= 1'b0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      if (trigger_o !== m_frozen) begin
         report_mismatch("trigger_o", 73'(trigger_o), 73'(m_frozen));
      end
      rows.delete();
   endtask

   task automatic verify_reg(input snoop_pkg::reg_addr_t addr,
                             input snoop_pkg::reg_data_t exp, input string name);
      read_reg(addr, rd_word);
      if (rd_word !== exp) begin
         report_mismatch(name, 73'(rd_word), 73'(exp));
      end
   endtask

   task automatic check_status();
      snoop_pkg::reg_data_t exp_count;
      exp_count     = 32'(model_q.size());
      exp_count[31] = m_frozen;
      verify_reg(snoop_pkg::REG_COUNT, exp_count, "COUNT");
      verify_reg(snoop_pkg::REG_FIRST, (m_n >= DEPTH) ? 32'(m_n % DEPTH) : 32'd0, "FIRST");
      verify_reg(snoop_pkg::REG_LAST, (m_n == 0) ? 32'd0 : 32'((m_n - 1) % DEPTH), "LAST");
   endtask

   // Oldest model record sits at FIRST
   task automatic check_buffer();
      snoop_pkg::trace_entry_t got;
      int                      first;
      int                      j;
      first = (m_n >= DEPTH) ? m_n % DEPTH : 0;
      for (j = 0; j < model_q.size(); j++) begin
         read_entry((first + j) % DEPTH, got);
         if (got !== model_q[j]) begin
            report_mismatch($sformatf("buf_rdata_o[%0d]", (first + j) % DEPTH),
                            got, model_q[j]);
         end
      end
   endtask

   task automatic begin_test();
      err_base = n_err;
   endtask

   task automatic end_test(input string name);
      n_tests++;
      if (n_err == err_base) begin
         $display("test %0d %s: passed", n_tests, name);
      end else begin
         n_failed++;
         $display("test %0d %s: failed with %0d errors", n_tests, name, n_err - err_base);
      end
   endtask

   initial begin
      int i;
      seed     = 32'hfcb0edb6;
      n_err    = 0;
      n_tests  = 0;
      n_failed = 0;
      m_en     = 1'b0;
      m_mask   = '0;
      m_tnum   = '0;
      m_lo     = '0;
      m_hi     = '0;
      m_tpc    = '0;
      m_n      = 0;
      m_match  = 0;
      m_frozen = 1'b0;
      rst_i         <= 1'b1;
      trace_valid_i <= 1'b0;
      pc_src_i      <= '0;
      pc_dst_i      <= '0;
      priv_i        <= '0;
      opcode_i      <= '0;
      cfg_we_i      <= 1'b0;
      cfg_re_i      <= 1'b0;
      cfg_addr_i    <= '0;
      cfg_wdata_i   <= '0;
      buf_re_i      <= 1'b0;
      buf_addr_i    <= '0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);

      // Reset values and register read back
      begin_test();
      if (trigger_o !== 1'b0) begin
         report_mismatch("trigger_o", 73'(trigger_o), 73'd0);
      end
      check_status();
      set_ctrl(1'b0, 1'b1, 4'b1010, 8'd5);
      verify_reg(snoop_pkg::REG_CTRL, ctrl_word(1'b0, 1'b0, 4'b1010, 8'd5), "CTRL");
      set_window(32'h0000_1000, 32'h0000_1fff, 32'hffff_fff0);
      verify_reg(snoop_pkg::REG_RANGE_LO, m_lo, "RANGE_LO");
      verify_reg(snoop_pkg::REG_RANGE_HI, m_hi, "RANGE_HI");
      verify_reg(snoop_pkg::REG_TRIG_PC, m_tpc, "TRIG_PC");
      end_test("reset and register access");

      // User and machine levels only, window 0x1000 to 0x1fff
      begin_test();
      set_ctrl(1'b1, 1'b0, 4'b1001, 8'd0);
      add_row(1'b1, 2'd0, 32'h0000_1000, 1'b1);
      add_row(1'b1, 2'd3, 32'h0000_1fff, 1'b1);
      add_row(1'b1, 2'd1, 32'h0000_1500, 1'b0);
      add_row(1'b1, 2'd2, 32'h0000_1500, 1'b0);
      add_row(1'b1, 2'd0, 32'h0000_0fff, 1'b0);
      add_row(1'b1, 2'd3, 32'h0000_2000, 1'b0);
      add_row(1'b0, 2'd0, 32'h0000_1200, 1'b0);
      add_row(1'b1, 2'd3, 32'h0000_1800, 1'b1);
      add_row(1'b1, 2'd0, 32'h0000_1004, 1'b1);
      apply_table();
      check_status();
      check_buffer();
      end_test("filtering");

      begin_test();
      set_ctrl(1'b1, 1'b1, 4'b1001, 8'd0);
      for (i = 0; i < 20; i++) begin
         add_row(1'b1, 2'd0, 32'h0000_1000 + 32'(i * 16), 1'b1);
      end
      apply_table();
      check_status();
      check_buffer();
      end_test("wrap");

      // Third accepted hit on 0x1100 freezes recording
      begin_test();
      set_window(32'h0000_1000, 32'h0000_1fff, 32'h0000_1100);
      set_ctrl(1'b1, 1'b1, 4'b1001, 8'd3);
      add_row(1'b1, 2'd0, 32'h0000_1100, 1'b1);
      add_row(1'b1, 2'd3, 32'h0000_1200, 1'b1);
      add_row(1'b1, 2'd1, 32'h0000_1100, 1'b0);
      add_row(1'b1, 2'd0, 32'h0000_1100, 1'b1);
      add_row(1'b0, 2'd3, 32'h0000_1100, 1'b0);
      add_row(1'b1, 2'd3, 32'h0000_1300, 1'b1);
      add_row(1'b1, 2'd3, 32'h0000_1100, 1'b1);
      add_row(1'b1, 2'd0, 32'h0000_1400, 1'b1);
      add_row(1'b1, 2'd0, 32'h0000_1100, 1'b1);
      apply_table();
      check_status();
      check_buffer();
      end_test("trigger");

      begin_test();
      set_ctrl(1'b1, 1'b1, 4'b1001, 8'd3);
      check_status();
      if (trigger_o !== 1'b0) begin
         report_mismatch("trigger_o", 73'(trigger_o), 73'd0);
      end
      for (i = 0; i < 5; i++) begin
         add_row(1'b1, 2'd3, 32'h0000_1800 + 32'(i * 4), 1'b1);
      end
      apply_table();
      check_status();
      check_buffer();
      // Disabled engine stores nothing
      set_ctrl(1'b0, 1'b0, 4'b1001, 8'd3);
      for (i = 0; i < 4; i++) begin
         add_row(1'b1, 2'd0, 32'h0000_1900 + 32'(i * 4), 1'b1);
      end
      apply_table();
      check_status();
      end_test("clear and disable");

      $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, n_err);
      if (n_err == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+tests
common/snoop_pkg.sv
design/wrap_counter.sv
design/trigger_unit.sv
snooper/snoop_cfg_regs.sv
snooper/trace_filter.sv
snooper/snoop_engine.sv
snooper/trace_buffer.sv
snooper/snooper_top.sv
tests/tb_snooper.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the snooper testbench with Verilator.
# Exits non-zero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_snooper \
   -Mdir obj_dir \
   -f project.f
if [ $? -ne 0 ]; then
   echo "run.sh: Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_snooper)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "run.sh: simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
   exit 0
fi
echo "run.sh: pass line not found"
exit 1
